//--- pi1_soc.f
+incdir+source
source/pi1_pkg.sv
source/soc_map_pkg.sv
source/rst_seq.sv
source/pi1_addr_decoder.sv
source/pi1_sram_dev.sv
source/pi1_resp_mux.sv
source/pi1_soc.sv
testbench/tb_pi1_soc.sv

//--- Bender.yml
package:
  name: pi1_soc

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/pi1_pkg.sv
      - source/soc_map_pkg.sv
      - source/rst_seq.sv
      - source/pi1_addr_decoder.sv
      - source/pi1_sram_dev.sv
      - source/pi1_resp_mux.sv
      - source/pi1_soc.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_pi1_soc.sv

//--- testbench/tb_pi1_soc.sv
/* PI1 subsystem testbench
   Table-driven and LFSR-driven bus traffic checked against a reference memory. */
`timescale 1ns/1ps

`include "soc_params.svh"

module tb_pi1_soc
	import pi1_pkg::*, soc_map_pkg::*;
();

	localparam int RST_CYCLES = 8;
	localparam int NSTIM      = 27;
	localparam int NRAND      = 200;
	localparam int MAPWORDS   = `SOC_DEVCOUNT * `SOC_DEVWORDS;
	localparam int WD_CYCLES  = (NSTIM + NRAND + RST_CYCLES + `SOC_RSTCYCLES) * 4;
	localparam int MAX_WAIT   = 8;

	typedef struct packed {
		pi1_op_t    op;
		pi1_addr_t  addr;
		pi1_data_t  data;
		pi1_sel_t   sel;
		pi1_data_t  exp;
		logic [2:0] grp;
	} step_t;

	logic      clk100mhz;
	logic      rst;
	pi1_op_t   pi1_op_i;
	pi1_addr_t pi1_addr_i;
	pi1_data_t pi1_data_i;
	pi1_sel_t  pi1_sel_i;
	logic      pi1_rdy_o;
	pi1_data_t pi1_data_o;

	step_t       stim [NSTIM];
	int          n_steps;
	pi1_data_t   ref_mem [MAPWORDS];
	logic [31:0] lfsr_q;
	string       test_name [1:6];

	// Read response due in the current cycle.
	logic      pend_q;
	pi1_data_t pend_exp;

	// Device that entered its swap cycle on the last accepting edge, or -1.
	int swap_dev;

	int err_count;
	int test_err_base;
	int pass_count;
	int fail_count;

	pi1_soc uut (
		 .clk100mhz  (clk100mhz)
		,.rst        (rst)
		,.pi1_op_i   (pi1_op_i)
		,.pi1_addr_i (pi1_addr_i)
		,.pi1_data_i (pi1_data_i)
		,.pi1_sel_i  (pi1_sel_i)
		,.pi1_rdy_o  (pi1_rdy_o)
		,.pi1_data_o (pi1_data_o)
	);

	initial begin
		clk100mhz = 1'b0;
	end

	always #5 clk100mhz = ~clk100mhz;

	function automatic pi1_data_t byte_mask(input pi1_sel_t sel);
		pi1_data_t m;
		for (int b = 0; b < $bits(pi1_sel_t); b++) begin
			m[b*8 +: 8] = {8{sel[b]}};
		end
		return m;
	endfunction

	// Fibonacci LFSR with taps at bits 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic add_step(input pi1_op_t op, input pi1_addr_t addr, input pi1_data_t data,
			input pi1_sel_t sel, input pi1_data_t exp, input int grp);
		stim[n_steps] = '{op, addr, data, sel, exp, 3'(grp)};
		n_steps++;
	endtask

	task automatic load_table();
		n_steps = 0;
		add_step(PI1_RDOP, 30'd0,   32'h0, 4'h0, 32'h0, 1);
		add_step(PI1_RDOP, 30'd71,  32'h0, 4'h0, 32'h0, 1);
		add_step(PI1_RDOP, 30'd191, 32'h0, 4'h0, 32'h0, 1);
		add_step(PI1_RDOP, 30'd193, 32'h0, 4'h0, 32'h0, 1);
		add_step(PI1_WROP, 30'd10, 32'h1122_3344, 4'hf,    32'h0, 2);
		add_step(PI1_WROP, 30'd10, 32'haabb_ccdd, 4'b0101, 32'h0, 2);
		add_step(PI1_RDOP, 30'd10, 32'h0,         4'h0,    32'h11bb_33dd, 2);
		add_step(PI1_RDWR, 30'd10,  32'hcafe_f00d, 4'hf,    32'h11bb_33dd, 3);
		add_step(PI1_RDOP, 30'd10,  32'h0,         4'h0,    32'hcafe_f00d, 3);
		add_step(PI1_RDWR, 30'd10,  32'h0000_0000, 4'b0011, 32'hcafe_f00d, 3);
		add_step(PI1_RDOP, 30'd138, 32'h0,         4'h0,    32'h0, 3);
		add_step(PI1_RDOP, 30'd10,  32'h0,         4'h0,    32'hcafe_0000, 3);
		add_step(PI1_WROP, 30'd5,   32'h0505_0000, 4'hf, 32'h0, 4);
		add_step(PI1_WROP, 30'd69,  32'h4545_0001, 4'hf, 32'h0, 4);
		add_step(PI1_WROP, 30'd133, 32'h8585_0002, 4'hf, 32'h0, 4);
		add_step(PI1_WROP, 30'd197, 32'hc5c5_0003, 4'hf, 32'h0, 4);
		add_step(PI1_RDOP, 30'd5,   32'h0, 4'h0, 32'h0505_0000, 4);
		add_step(PI1_RDOP, 30'd69,  32'h0, 4'h0, 32'h4545_0001, 4);
		add_step(PI1_RDOP, 30'd133, 32'h0, 4'h0, 32'h8585_0002, 4);
		add_step(PI1_RDOP, 30'd197, 32'h0, 4'h0, 32'hc5c5_0003, 4);
		add_step(PI1_RDOP, 30'd256,         32'h0,         4'h0, 32'h0, 5);
		add_step(PI1_RDOP, 30'h3fff_ffff,   32'h0,         4'h0, 32'h0, 5);
		add_step(PI1_WROP, 30'd256,         32'hffff_ffff, 4'hf, 32'h0, 5);
		add_step(PI1_WROP, 30'd320,         32'hffff_ffff, 4'hf, 32'h0, 5);
		add_step(PI1_RDOP, 30'd0,           32'h0,         4'h0, 32'h0, 5);
		add_step(PI1_RDOP, 30'd64,          32'h0,         4'h0, 32'h0, 5);
		add_step(PI1_RDOP, 30'd256,         32'h0,         4'h0, 32'h0, 5);
	endtask

	// One clock cycle with the inputs as they stand. The response owed to
	// the previous acceptance is checked, and acceptance is sampled mid-cycle.
	task automatic bus_cycle(output logic accepted);
		@(negedge clk100mhz);
		if (pend_q) begin
			if (pi1_data_o !== pend_exp) begin
				$display("FAILED t=%0t pi1_data_o expected %h got %h",
					$time, pend_exp, pi1_data_o);
				err_count++;
			end
		end
		accepted = (pi1_rdy_o === 1'b1) && (pi1_op_i != PI1_NOP);
		@(posedge clk100mhz);
		#1;
		pend_q = 1'b0;
	endtask

	task automatic issue(input pi1_op_t op, input pi1_addr_t addr, input pi1_data_t data,
			input pi1_sel_t sel, input pi1_data_t exp);
		logic      accepted;
		logic      in_map;
		int        dev;
		int        waits;
		int        exp_waits;
		pi1_data_t mask;
		in_map    = (addr < MAPWORDS);
		dev       = in_map ? int'(addr) / `SOC_DEVWORDS : -1;
		exp_waits = (in_map && (dev == swap_dev)) ? 1 : 0;
		mask      = byte_mask(sel);
		pi1_op_i   = op;
		pi1_addr_i = addr;
		pi1_data_i = data;
		pi1_sel_i  = sel;
		waits = 0;
		bus_cycle(accepted);
		while (!accepted && (waits < MAX_WAIT)) begin
			waits++;
			bus_cycle(accepted);
		end
		if (!accepted) begin
			$display("ERROR t=%0t request to address %h was never accepted", $time, addr);
			err_count++;
		end else if (waits != exp_waits) begin
			$display("FAILED t=%0t pi1_rdy_o stall cycles expected %0d got %0d",
				$time, exp_waits, waits);
			err_count++;
		end
		if ((op == PI1_RDOP) || (op == PI1_RDWR)) begin
			pend_q   = accepted;
			pend_exp = exp;
		end
		if (accepted && in_map && ((op == PI1_WROP) || (op == PI1_RDWR))) begin
			ref_mem[addr] = (ref_mem[addr] & ~mask) | (data & mask);
		end
		swap_dev = (accepted && in_map && (op == PI1_RDWR)) ? dev : -1;
		pi1_op_i = PI1_NOP;
	endtask

	task automatic idle_cycle();
		logic accepted;
		pi1_op_i = PI1_NOP;
		bus_cycle(accepted);
		swap_dev = -1;
	endtask

	task automatic finish_test(input int num);
		idle_cycle();
		if (err_count == test_err_base) begin
			pass_count++;
			$display("test %0d %s: passed", num, test_name[num]);
		end else begin
			fail_count++;
			$display("test %0d %s: failed with %0d errors", num, test_name[num],
				err_count - test_err_base);
		end
		test_err_base = err_count;
	endtask

	initial begin
		#(WD_CYCLES * 10);
		$display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		int          low_cycles;
		int          cur_grp;
		logic [31:0] r;
		pi1_op_t     op;
		pi1_addr_t   addr;
		pi1_data_t   data;
		pi1_data_t   exp;
		pi1_sel_t    sel;
		rst        = 1'b1;
		pi1_op_i   = PI1_NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		lfsr_q     = 32'h1e7e_29f0;
		pend_q     = 1'b0;
		pend_exp   = '0;
		swap_dev   = -1;
		err_count     = 0;
		test_err_base = 0;
		pass_count    = 0;
		fail_count    = 0;
		test_name[1] = "reset stretch";
		test_name[2] = "byte-select writes";
		test_name[3] = "read-and-swap";
		test_name[4] = "device isolation";
		test_name[5] = "invalid region";
		test_name[6] = "random traffic";
		for (int w = 0; w < MAPWORDS; w++) begin
			ref_mem[w] = '0;
		end
		load_table();

		repeat (RST_CYCLES) @(posedge clk100mhz);
		#1;
		rst = 1'b0;

		// Address 0 points at device 0, whose ready follows the fabric reset.
		low_cycles = 0;
		@(negedge clk100mhz);
		while ((pi1_rdy_o !== 1'b1) && (low_cycles < 4 * `SOC_RSTCYCLES)) begin
			low_cycles++;
			@(negedge clk100mhz);
		end
		if (low_cycles != `SOC_RSTCYCLES) begin
			$display("FAILED t=%0t pi1_rdy_o low cycles expected %0d got %0d",
				$time, `SOC_RSTCYCLES, low_cycles);
			err_count++;
		end
		@(posedge clk100mhz);
		#1;

		cur_grp = stim[0].grp;
		for (int i = 0; i < NSTIM; i++) begin
			if (stim[i].grp != cur_grp) begin
				finish_test(cur_grp);
				cur_grp = stim[i].grp;
			end
			issue(stim[i].op, stim[i].addr, stim[i].data, stim[i].sel, stim[i].exp);
		end
		finish_test(cur_grp);

		for (int i = 0; i < NRAND; i++) begin
			take_bits(2, r);
			op = pi1_op_t'(r);
			if (op == PI1_NOP) begin
				op = PI1_RDOP;
			end
			take_bits(8, r);
			addr = pi1_addr_t'(r);
			// About one request in eight lands somewhere above the map.
			take_bits(3, r);
			if (r == 0) begin
				take_bits(22, r);
				addr = addr | (pi1_addr_t'(r) << 8) | pi1_addr_t'(MAPWORDS);
			end
			take_bits(32, r);
			data = r;
			take_bits(4, r);
			sel = pi1_sel_t'(r);
			if (addr < MAPWORDS) begin
				exp = ref_mem[addr];
			end else begin
				exp = '0;
			end
			issue(op, addr, data, sel, exp);
		end
		finish_test(6);

		$display("tests passed: %0d, tests failed: %0d, errors: %0d",
			pass_count, fail_count, err_count);
		if ((fail_count == 0) && (err_count == 0)) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- source/pi1_soc.sv
/* PI1 peripheral-bus subsystem
   One master port decoded onto an array of scratch memories. */
`timescale 1ns/1ps

`include "soc_params.svh"

module pi1_soc
	import pi1_pkg::*, soc_map_pkg::*;
(
	 input  logic      clk100mhz
	,input  logic      rst

	,input  pi1_op_t   pi1_op_i
	,input  pi1_addr_t pi1_addr_i
	,input  pi1_data_t pi1_data_i
	,input  pi1_sel_t  pi1_sel_i
	,output logic      pi1_rdy_o
	,output pi1_data_t pi1_data_o
);

	logic                          fab_rst_w;

	pi1_op_t [`SOC_DEVCOUNT-1:0]   dev_op_w;
	dev_off_t                      dev_off_w;
	logic [`SOC_DEVCOUNT-1:0]      dev_rdy_w;
	pi1_data_t [`SOC_DEVCOUNT-1:0] dev_rdata_w;

	logic                          acc_w;
	dev_idx_t                      acc_idx_w;

	rst_seq rst_seq (
		 .clk100mhz (clk100mhz)
		,.rst       (rst)
		,.fab_rst_o (fab_rst_w)
	);

	pi1_addr_decoder decoder (
		 .pi1_op_i   (pi1_op_i)
		,.pi1_addr_i (pi1_addr_i)
		,.pi1_rdy_o  (pi1_rdy_o)
		,.dev_op_o   (dev_op_w)
		,.dev_off_o  (dev_off_w)
		,.dev_rdy_i  (dev_rdy_w)
		,.acc_o      (acc_w)
		,.acc_idx_o  (acc_idx_w)
	);

	// Write data and lane selects go to every device unchanged. Only the
	// addressed one sees an op other than NOP.
	for (genvar d = 0; d < `SOC_DEVCOUNT; d++) begin : gen_dev
		pi1_sram_dev sram (
			 .clk100mhz (clk100mhz)
			,.rst_i     (fab_rst_w)
			,.op_i      (dev_op_w[d])
			,.off_i     (dev_off_w)
			,.data_i    (pi1_data_i)
			,.sel_i     (pi1_sel_i)
			,.rdata_o   (dev_rdata_w[d])
			,.rdy_o     (dev_rdy_w[d])
		);
	end

	pi1_resp_mux resp_mux (
		 .clk100mhz   (clk100mhz)
		,.rst_i       (fab_rst_w)
		,.acc_i       (acc_w)
		,.acc_idx_i   (acc_idx_w)
		,.dev_rdata_i (dev_rdata_w)
		,.pi1_data_o  (pi1_data_o)
	);

endmodule

//--- source/pi1_resp_mux.sv
/* PI1 response multiplexer
   Returns the read data of the target that accepted the previous request. */
`timescale 1ns/1ps

`include "soc_params.svh"

module pi1_resp_mux
	import pi1_pkg::*, soc_map_pkg::*;
(
	 input  logic                          clk100mhz
	,input  logic                          rst_i

	,input  logic                          acc_i
	,input  dev_idx_t                      acc_idx_i

	,input  pi1_data_t [`SOC_DEVCOUNT-1:0] dev_rdata_i
	,output pi1_data_t                     pi1_data_o
);

	localparam int SELW = $clog2(`SOC_DEVCOUNT);

	logic     acc_q;
	dev_idx_t idx_q;

	// The devices register their read word on the accepting edge, so the
	// index is registered alongside it.
	always_ff @(posedge clk100mhz) begin
		if (rst_i) begin
			acc_q <= 1'b0;
			idx_q <= '0;
		end else begin
			acc_q <= acc_i;
			idx_q <= acc_idx_i;
		end
	end

	// Zero for the invalid region and in cycles with no read response.
	always_comb begin
		pi1_data_o = '0;
		if (acc_q && (idx_q < dev_idx_t'(`SOC_DEVCOUNT))) begin
			pi1_data_o = dev_rdata_i[idx_q[SELW-1:0]];
		end
	end

endmodule

//--- source/pi1_sram_dev.sv
/* PI1 scratch-memory device
   Word array with byte-lane writes and a two-cycle read-and-swap. */
`timescale 1ns/1ps

`include "soc_params.svh"

module pi1_sram_dev
	import pi1_pkg::*, soc_map_pkg::*;
(
	 input  logic      clk100mhz
	,input  logic      rst_i

	,input  pi1_op_t   op_i
	,input  dev_off_t  off_i
	,input  pi1_data_t data_i
	,input  pi1_sel_t  sel_i
	,output pi1_data_t rdata_o
	,output logic      rdy_o
);

	dev_state_t state_q;

	pi1_data_t  mem_q [`SOC_DEVWORDS];

	// Write half of a pending read-and-swap.
	pi1_data_t  swap_data_q;
	dev_off_t   swap_off_q;
	pi1_sel_t   swap_sel_q;

	logic       idle_w;

	// Replaces the selected byte lanes of a word.
	function automatic pi1_data_t lane_merge(
		input pi1_data_t old_word,
		input pi1_data_t new_word,
		input pi1_sel_t  sel
	);
		pi1_data_t res;
		res = old_word;
		for (int b = 0; b < $bits(pi1_sel_t); b++) begin
			if (sel[b]) begin
				res[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return res;
	endfunction

	assign idle_w = (state_q == DEV_IDLE);

	// Held low while the fabric is in reset and during the swap cycle.
	assign rdy_o = !rst_i && idle_w;

	always_ff @(posedge clk100mhz) begin
		if (rst_i) begin
			state_q <= DEV_IDLE;
			for (int w = 0; w < `SOC_DEVWORDS; w++) begin
				mem_q[w] <= '0;
			end
		end else begin
			case (state_q)
				DEV_IDLE: begin
					if (op_i == PI1_WROP) begin
						mem_q[off_i] <= lane_merge(mem_q[off_i], data_i, sel_i);
					end
					if (op_i == PI1_RDWR) begin
						state_q <= DEV_SWAP;
					end
				end
				DEV_SWAP: begin
					mem_q[swap_off_q] <= lane_merge(mem_q[swap_off_q], swap_data_q,
						swap_sel_q);
					state_q <= DEV_IDLE;
				end
				default: begin
					state_q <= DEV_IDLE;
				end
			endcase
		end
	end

	// Read data and the swap operands. A read-and-swap returns the word as
	// it was before its own write lands.
	always_ff @(posedge clk100mhz) begin
		if (idle_w && ((op_i == PI1_RDOP) || (op_i == PI1_RDWR))) begin
			rdata_o <= mem_q[off_i];
		end
		if (idle_w && (op_i == PI1_RDWR)) begin
			swap_data_q <= data_i;
			swap_off_q  <= off_i;
			swap_sel_q  <= sel_i;
		end
	end

endmodule

//--- source/pi1_addr_decoder.sv
/* PI1 address decoder
   Splits the word address into target and offset, and steers op and ready. */
`timescale 1ns/1ps

`include "soc_params.svh"

module pi1_addr_decoder
	import pi1_pkg::*, soc_map_pkg::*;
(
	 input  pi1_op_t                       pi1_op_i
	,input  pi1_addr_t                     pi1_addr_i
	,output logic                          pi1_rdy_o

	,output pi1_op_t [`SOC_DEVCOUNT-1:0]   dev_op_o
	,output dev_off_t                      dev_off_o
	,input  logic [`SOC_DEVCOUNT-1:0]      dev_rdy_i

	,output logic                          acc_o
	,output dev_idx_t                      acc_idx_o
);

	localparam int OFFW = $bits(dev_off_t);
	localparam int SELW = $clog2(`SOC_DEVCOUNT);
	localparam dev_idx_t INVALID_IDX = dev_idx_t'(`SOC_DEVCOUNT);

	logic     in_map_w;
	dev_idx_t idx_w;
	logic     is_read_w;

	// Everything from the end of the last device window upwards belongs
	// to the invalid region.
	assign in_map_w = (pi1_addr_i < pi1_addr_t'(`SOC_DEVCOUNT * `SOC_DEVWORDS));

	assign idx_w = in_map_w ? dev_idx_t'(pi1_addr_i >> OFFW) : INVALID_IDX;

	assign dev_off_o = pi1_addr_i[OFFW-1:0];

	// Only the addressed device sees the op. All others get a NOP.
	always_comb begin
		for (int d = 0; d < `SOC_DEVCOUNT; d++) begin
			if (idx_w == dev_idx_t'(d)) begin
				dev_op_o[d] = pi1_op_i;
			end else begin
				dev_op_o[d] = PI1_NOP;
			end
		end
	end

	// The invalid region never stalls.
	assign pi1_rdy_o = in_map_w ? dev_rdy_i[idx_w[SELW-1:0]] : 1'b1;

	assign is_read_w = (pi1_op_i == PI1_RDOP) || (pi1_op_i == PI1_RDWR);

	// A read-type request is accepted on this edge, so the mux must return
	// this target's data in the next cycle.
	assign acc_o     = pi1_rdy_o && is_read_w;
	assign acc_idx_o = idx_w;

endmodule

//--- source/rst_seq.sv
/* Reset sequencer
   Holds the fabric in reset for a fixed number of cycles after rst ends. */
`timescale 1ns/1ps

`include "soc_params.svh"

module rst_seq (
	 input  logic clk100mhz
	,input  logic rst
	,output logic fab_rst_o
);

	localparam int CNTW = $clog2(`SOC_RSTCYCLES + 1);

	logic [CNTW-1:0] rst_cntr;

	// The counter reloads while the external reset is held and runs down
	// to zero once it is released.
	always_ff @(posedge clk100mhz) begin
		if (rst) begin
			rst_cntr <= CNTW'(`SOC_RSTCYCLES);
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	assign fab_rst_o = rst || (rst_cntr != '0);

endmodule

//--- source/soc_map_pkg.sv
/* Memory-map package
   Target index, in-device word offset and the device state machine. */
`include "soc_params.svh"

package soc_map_pkg;

	// Target of a request. Values below the device count name a device;
	// the value equal to the device count names the invalid region.
	typedef logic [$clog2(`SOC_DEVCOUNT+1)-1:0] dev_idx_t;

	// Word offset inside one device window.
	typedef logic [$clog2(`SOC_DEVWORDS)-1:0] dev_off_t;

	// A device is idle and ready, or it is committing the write half
	// of a read-and-swap and holds its ready low.
	typedef enum logic [0:0] {
		DEV_IDLE,
		DEV_SWAP
	} dev_state_t;

endpackage

//--- source/pi1_pkg.sv
/* PI1 bus package
   Word, address, select and opcode types with the opcode encodings. */
`include "soc_params.svh"

package pi1_pkg;

	// One bus word.
	typedef logic [`SOC_ARCHBITSZ-1:0] pi1_data_t;

	// Word address. The byte bits below a word are not carried on the bus.
	typedef logic [`SOC_ARCHBITSZ-$clog2(`SOC_ARCHBITSZ/8)-1:0] pi1_addr_t;

	// One select bit per byte lane.
	typedef logic [`SOC_ARCHBITSZ/8-1:0] pi1_sel_t;

	typedef logic [1:0] pi1_op_t;

	// No request on the bus.
	localparam pi1_op_t PI1_NOP  = 2'd0;

	// Read the old word and write the new one in the same request.
	localparam pi1_op_t PI1_RDWR = 2'd1;

	localparam pi1_op_t PI1_WROP = 2'd2;

	localparam pi1_op_t PI1_RDOP = 2'd3;

endpackage

//--- source/soc_params.svh
/* SoC build parameters
   Bus width, device count and size, and the fabric reset stretch. */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Width of a bus word in bits.
`define SOC_ARCHBITSZ 32

// Number of identical scratch-memory devices on the bus.
`define SOC_DEVCOUNT 4

// Words in each device window. This must be a power of two.
`define SOC_DEVWORDS 64

// Cycles that the fabric stays in reset after the external reset ends.
`define SOC_RSTCYCLES 16

`endif
